// ==== hw/axi_write_former.sv ====
/*
 * AXI write burst former
 * Turns a page-bounded chunk into an AW burst plus write data-path fields
 */
`default_nettype none

module axi_write_former import legalizer_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  reset_i,
    input  wire logic  load_i,
    input  wire addr_t start_addr_i,
    input  wire logic  flush_i,
    chunk_if.former    chunk,
    input  wire logic  w_ready_i,
    output logic       w_valid_o,
    output addr_t      aw_addr_o,
    output beats_t     aw_len_o,
    output offset_t    w_offset_o,
    output offset_t    w_tailer_o,
    output offset_t    w_shift_o,
    output logic       w_last_o
);

    offset_t    write_shift_q;
    offset_t    chunk_offset;
    // Bytes from the aligned burst start to the chunk end
    chunk_len_t burst_span;
    chunk_len_t burst_words;

    // --------------------
    // Handshake
    // --------------------
    assign w_valid_o   = chunk.valid & ~flush_i;
    assign chunk.ready = w_ready_i;

    // --------------------
    // AW burst
    // --------------------
    assign chunk_offset = chunk.addr[OFFSET_W-1:0];

    // Burst starts on a word boundary
    assign aw_addr_o = {chunk.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // Never above PAGE_SIZE since the chunk stays inside one page
    assign burst_span = chunk.num_bytes + chunk_len_t'(chunk_offset);

    // Beats minus one, upper bits always zero
    assign burst_words = (burst_span - chunk_len_t'(1)) >> OFFSET_W;
    assign aw_len_o    = beats_t'(burst_words);

    // --------------------
    // Write data path
    // --------------------
    assign w_offset_o = chunk_offset;

    // Strobe end position in the final beat
    assign w_tailer_o = offset_t'(burst_span);

    // Marks the burst that closes the 1D transfer
    assign w_last_o = chunk.last;

    // Realign from word order to destination order
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            write_shift_q <= '0;
        end else if (load_i) begin
            write_shift_q <= offset_t'(-start_addr_i[OFFSET_W-1:0]);
        end
    end

    assign w_shift_o = write_shift_q;

endmodule

`default_nettype wire

// ==== hw/chunk_if.sv ====
/*
 * Legalized chunk link
 * One chunk moves from a walker to its request former per valid/ready handshake
 */
`default_nettype none

interface chunk_if import legalizer_pkg::*; ();

    // Walker holds a chunk
    logic       valid;
    // Downstream of the former accepts it
    logic       ready;
    // First byte address of the chunk
    addr_t      addr;
    // Byte count of the chunk
    chunk_len_t num_bytes;
    // Final chunk of the transfer
    logic       last;

    modport walker (
        output valid, addr, num_bytes, last,
        input  ready
    );

    modport former (
        input  valid, addr, num_bytes, last,
        output ready
    );

endinterface

`default_nettype wire

// ==== hw/chunk_walker.sv ====
/*
 * Chunk walker
 * Holds the remaining part of one side's transfer and cuts it at a boundary
 */
`default_nettype none

module chunk_walker import legalizer_pkg::*; #(
    // Power of two, at most PAGE_SIZE
    parameter int unsigned BOUNDARY_BYTES = PAGE_SIZE
) (
    input  wire logic  clk_i,
    input  wire logic  reset_i,
    input  wire logic  load_i,
    input  wire logic  kill_i,
    input  wire logic  flush_i,
    input  wire addr_t start_addr_i,
    input  wire len_t  length_i,
    chunk_if.walker    chunk,
    output logic       busy_o
);

    // Low address bits that lie inside one boundary window
    localparam addr_t BOUNDARY_MASK = addr_t'(BOUNDARY_BYTES - 1);

    // Stored transfer state
    addr_t      addr_q;
    len_t       len_q;
    logic       valid_q;

    // Current chunk
    chunk_len_t dist_to_bound;
    logic       fits;
    logic       step;

    // --------------------
    // Chunk forming
    // --------------------
    // Bytes left before the next boundary
    assign dist_to_bound = chunk_len_t'(BOUNDARY_BYTES)
                         - chunk_len_t'(addr_q & BOUNDARY_MASK);

    // Rest of the transfer fits in this window
    assign fits = (len_q <= len_t'(dist_to_bound));

    assign chunk.valid     = valid_q;
    assign chunk.addr      = addr_q;
    assign chunk.last      = fits;
    assign chunk.num_bytes = fits ? chunk_len_t'(len_q) : dist_to_bound;

    // Handshake only counts while not flushing
    assign step = valid_q & chunk.ready & ~flush_i;

    // --------------------
    // Valid bit
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            // New transfer beats a kill in the same cycle
            valid_q <= 1'b1;
        end else if (kill_i) begin
            valid_q <= 1'b0;
        end else if (step && fits) begin
            // Last chunk handed over, go idle
            valid_q <= 1'b0;
        end
    end

    // --------------------
    // Address and length
    // --------------------
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            addr_q <= start_addr_i;
            len_q  <= length_i;
        end else if (step && !fits) begin
            // Jump to the boundary and drop the bytes just sent
            addr_q <= addr_q + addr_t'(dist_to_bound);
            len_q  <= len_q - len_t'(dist_to_bound);
        end
    end

    // Busy for as long as a chunk is pending
    assign busy_o = valid_q;

endmodule

`default_nettype wire

// ==== hw/legalizer_pkg.sv ====
/*
 * Burst legalizer shared definitions
 * Bus widths, AXI page size and the vector types used across the design
 */
`default_nettype none

package legalizer_pkg;

    // --------------------
    // Bus geometry
    // --------------------
    localparam int unsigned ADDR_W   = 32;
    localparam int unsigned DATA_W   = 32;
    localparam int unsigned LEN_W    = 32;
    // Bytes per data word
    localparam int unsigned STRB_W   = DATA_W / 8;
    // Byte offset inside a word
    localparam int unsigned OFFSET_W = $clog2(STRB_W);

    // --------------------
    // AXI page
    // --------------------
    // 256 beats max, but never past the 4 KiB boundary
    localparam int unsigned PAGE_SIZE = (256 * STRB_W > 4096) ? 4096 : 256 * STRB_W;
    localparam int unsigned PAGE_W    = $clog2(PAGE_SIZE);
    // AXI len field, beats minus one
    localparam int unsigned BEATS_W   = 8;

    // --------------------
    // Vector types
    // --------------------
    // Byte address
    typedef logic [ADDR_W-1:0]   addr_t;
    // Byte length of a whole transfer
    typedef logic [LEN_W-1:0]    len_t;
    // Bytes in one chunk, 0 up to PAGE_SIZE inclusive
    typedef logic [PAGE_W:0]     chunk_len_t;
    // Offset, tailer and shift within a word
    typedef logic [OFFSET_W-1:0] offset_t;
    // AXI beat count minus one
    typedef logic [BEATS_W-1:0]  beats_t;

endpackage

`default_nettype wire

// ==== hw/legalizer_top.sv ====
/*
 * Burst legalizer top level
 * Splits a 1D transfer into OBI word reads and page-safe AXI write bursts
 */
`default_nettype none

module legalizer_top import legalizer_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // Transfer request
    input  wire logic  req_valid_i,
    output logic       req_ready_o,
    input  wire addr_t src_addr_i,
    input  wire addr_t dst_addr_i,
    input  wire len_t  length_i,

    // OBI read side
    output logic       r_valid_o,
    input  wire logic  r_ready_i,
    output addr_t      r_addr_o,
    output offset_t    r_offset_o,
    output offset_t    r_tailer_o,
    output offset_t    r_shift_o,

    // AXI write side
    output logic       w_valid_o,
    input  wire logic  w_ready_i,
    output addr_t      aw_addr_o,
    output beats_t     aw_len_o,
    output offset_t    w_offset_o,
    output offset_t    w_tailer_o,
    output offset_t    w_shift_o,
    output logic       w_last_o,

    // Control and status
    input  wire logic  flush_i,
    input  wire logic  kill_i,
    output logic       r_busy_o,
    output logic       w_busy_o
);

    chunk_if r_chunk ();
    chunk_if w_chunk ();

    // Side idle or on its final chunk
    logic r_done;
    logic w_done;
    logic load;

    // --------------------
    // Request acceptance
    // --------------------
    assign r_done = ~r_chunk.valid | r_chunk.last;
    assign w_done = ~w_chunk.valid | w_chunk.last;

    // Next request rides on the final handshakes of both sides
    assign req_ready_o = r_done & w_done & r_ready_i & w_ready_i & ~flush_i;

    // Shared load pulse for walkers and shift registers
    assign load = req_valid_i & req_ready_o;

    // --------------------
    // Read side
    // --------------------
    // OBI moves one word per request
    chunk_walker #(
        .BOUNDARY_BYTES(STRB_W)
    ) read_walker_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (load),
        .kill_i       (kill_i),
        .flush_i      (flush_i),
        .start_addr_i (src_addr_i),
        .length_i     (length_i),
        .chunk        (r_chunk.walker),
        .busy_o       (r_busy_o)
    );

    obi_read_former read_former_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (load),
        .start_addr_i (src_addr_i),
        .flush_i      (flush_i),
        .chunk        (r_chunk.former),
        .r_ready_i    (r_ready_i),
        .r_valid_o    (r_valid_o),
        .r_addr_o     (r_addr_o),
        .r_offset_o   (r_offset_o),
        .r_tailer_o   (r_tailer_o),
        .r_shift_o    (r_shift_o)
    );

    // --------------------
    // Write side
    // --------------------
    // Bursts cut at AXI page boundaries
    chunk_walker #(
        .BOUNDARY_BYTES(PAGE_SIZE)
    ) write_walker_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (load),
        .kill_i       (kill_i),
        .flush_i      (flush_i),
        .start_addr_i (dst_addr_i),
        .length_i     (length_i),
        .chunk        (w_chunk.walker),
        .busy_o       (w_busy_o)
    );

    axi_write_former write_former_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (load),
        .start_addr_i (dst_addr_i),
        .flush_i      (flush_i),
        .chunk        (w_chunk.former),
        .w_ready_i    (w_ready_i),
        .w_valid_o    (w_valid_o),
        .aw_addr_o    (aw_addr_o),
        .aw_len_o     (aw_len_o),
        .w_offset_o   (w_offset_o),
        .w_tailer_o   (w_tailer_o),
        .w_shift_o    (w_shift_o),
        .w_last_o     (w_last_o)
    );

endmodule

`default_nettype wire

// ==== hw/obi_read_former.sv ====
/*
 * OBI read request former
 * Turns a word chunk into an OBI read request plus read data-path fields
 */
`default_nettype none

module obi_read_former import legalizer_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  reset_i,
    input  wire logic  load_i,
    input  wire addr_t start_addr_i,
    input  wire logic  flush_i,
    chunk_if.former    chunk,
    input  wire logic  r_ready_i,
    output logic       r_valid_o,
    output addr_t      r_addr_o,
    output offset_t    r_offset_o,
    output offset_t    r_tailer_o,
    output offset_t    r_shift_o
);

    offset_t read_shift_q;
    offset_t chunk_offset;

    // --------------------
    // Handshake
    // --------------------
    // Flush holds the request back
    assign r_valid_o   = chunk.valid & ~flush_i;
    assign chunk.ready = r_ready_i;

    // --------------------
    // Request fields
    // --------------------
    // Byte position of the first valid byte in the word
    assign chunk_offset = chunk.addr[OFFSET_W-1:0];

    // OBI always reads whole words
    assign r_addr_o = {chunk.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign r_offset_o = chunk_offset;

    // End position wraps within the word
    assign r_tailer_o = offset_t'(chunk.num_bytes + chunk_len_t'(chunk_offset));

    // --------------------
    // Read shift
    // --------------------
    // Source misalignment, kept for the whole transfer
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            read_shift_q <= '0;
        end else if (load_i) begin
            read_shift_q <= start_addr_i[OFFSET_W-1:0];
        end
    end

    assign r_shift_o = read_shift_q;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tests
hw/legalizer_pkg.sv
hw/chunk_if.sv
hw/chunk_walker.sv
hw/obi_read_former.sv
hw/axi_write_former.sv
hw/legalizer_top.sv
tests/tb_legalizer.sv

// ==== tests/legalizer_checks.svh ====
/*
 * Legalizer reference rules and handshake checks
 * Expected chunk fields derived from the transfer geometry and the scoreboard
 */
`ifndef LEGALIZER_CHECKS_SVH
`define LEGALIZER_CHECKS_SVH

// --------------------
// Failure reporting
// --------------------
task automatic fail_value(input string name, input logic [63:0] got,
                          input logic [63:0] exp);
    $display("Checks failed");
    $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    $fatal(1, "wrong value on %s", name);
endtask

task automatic fail_plain(input string what);
    $display("Checks failed");
    $display("Error at t=%0t, %s", $time, what);
    $fatal(1, "%s", what);
endtask

// --------------------
// Reference rules
// --------------------
// Bytes still owed up to the next boundary
function automatic int unsigned chunk_bytes(input addr_t addr, input int unsigned rem,
                                            input int unsigned bound);
    int unsigned room;
    room = bound - (addr % bound);
    return (rem < room) ? rem : room;
endfunction

// One OBI word request against the read scoreboard
task automatic check_read();
    int unsigned cnt;
    offset_t     off;
    cnt = chunk_bytes(exp_r_addr, r_rem, STRB_W);
    off = exp_r_addr[1:0];
    assert (r_rem != 0) else fail_plain("read request after the transfer ended");
    assert (r_addr_o == {exp_r_addr[31:2], 2'b00})
        else fail_value("r_addr_o", r_addr_o, {exp_r_addr[31:2], 2'b00});
    assert (r_offset_o == off) else fail_value("r_offset_o", r_offset_o, off);
    assert (r_tailer_o == 2'(cnt + off))
        else fail_value("r_tailer_o", r_tailer_o, 2'(cnt + off));
    assert (r_shift_o == exp_r_shift) else fail_value("r_shift_o", r_shift_o, exp_r_shift);
    exp_r_addr = exp_r_addr + cnt;
    r_rem      = r_rem - cnt;
endtask

// One AW burst against the write scoreboard
task automatic check_write();
    int unsigned cnt;
    int unsigned span;
    offset_t     off;
    cnt  = chunk_bytes(exp_w_addr, w_rem, PAGE_SIZE);
    off  = exp_w_addr[1:0];
    span = cnt + off;
    assert (w_rem != 0) else fail_plain("write burst after the transfer ended");
    // Burst end from the DUT's own fields
    assert ((aw_addr_o % PAGE_SIZE) + (int'(aw_len_o) + 1) * STRB_W <= PAGE_SIZE)
        else fail_plain("AXI burst crosses a 1 KiB page");
    assert (aw_addr_o == {exp_w_addr[31:2], 2'b00})
        else fail_value("aw_addr_o", aw_addr_o, {exp_w_addr[31:2], 2'b00});
    assert (aw_len_o == 8'((span - 1) / STRB_W))
        else fail_value("aw_len_o", aw_len_o, (span - 1) / STRB_W);
    assert (w_offset_o == off) else fail_value("w_offset_o", w_offset_o, off);
    assert (w_tailer_o == 2'(span)) else fail_value("w_tailer_o", w_tailer_o, 2'(span));
    assert (w_last_o == (cnt == w_rem)) else fail_value("w_last_o", w_last_o, cnt == w_rem);
    assert (w_shift_o == exp_w_shift) else fail_value("w_shift_o", w_shift_o, exp_w_shift);
    exp_w_addr = exp_w_addr + cnt;
    w_rem      = w_rem - cnt;
endtask

`endif

// ==== tests/tb_legalizer.sv ====
/*
 * Burst legalizer testbench
 * Random transfers under back-pressure, flush and kill against a scoreboard
 */
`default_nettype none

module tb_legalizer import legalizer_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned NUM_XFERS = 40;
    // Cycle limit of each wait loop
    localparam int unsigned WAIT_MAX  = 20000;

    integer      seed = 80020;
    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        req_valid_i;
    logic        req_ready_o;
    addr_t       src_addr_i;
    addr_t       dst_addr_i;
    len_t        length_i;
    logic        r_valid_o;
    logic        r_ready_i;
    addr_t       r_addr_o;
    offset_t     r_offset_o;
    offset_t     r_tailer_o;
    offset_t     r_shift_o;
    logic        w_valid_o;
    logic        w_ready_i;
    addr_t       aw_addr_o;
    beats_t      aw_len_o;
    offset_t     w_offset_o;
    offset_t     w_tailer_o;
    offset_t     w_shift_o;
    logic        w_last_o;
    logic        flush_i;
    logic        kill_i;
    logic        r_busy_o;
    logic        w_busy_o;

    // --------------------
    // Scoreboard state
    // --------------------
    addr_t       exp_r_addr;
    addr_t       exp_w_addr;
    // Bytes each side still owes
    int unsigned r_rem;
    int unsigned w_rem;
    offset_t     exp_r_shift;
    offset_t     exp_w_shift;
    // Random readies and flush enabled
    logic        rand_ctrl;
    // Side was stalled at the last sample
    logic        r_hold;
    logic        w_hold;
    logic [37:0] r_snap;
    logic [46:0] w_snap;

    always #2 clk_i = ~clk_i;

    legalizer_top legalizer_top_inst (.*);

    `include "legalizer_checks.svh"

    // Independent readies, flush now and then
    always @(posedge clk_i) begin
        if (rand_ctrl) begin
            r_ready_i <= ($random(seed) & 3) != 0;
            w_ready_i <= ($random(seed) & 3) != 0;
            flush_i   <= ($random(seed) & 15) == 0;
        end
    end

    // --------------------
    // Monitor
    // --------------------
    // Sampled mid-cycle, the handshakes take effect at the next rising edge
    always @(negedge clk_i) begin : monitor
        logic [37:0] r_now;
        logic [46:0] w_now;
        r_now = {r_addr_o, r_offset_o, r_tailer_o, r_shift_o};
        w_now = {aw_addr_o, aw_len_o, w_offset_o, w_tailer_o, w_shift_o, w_last_o};
        if (!reset_i) begin
            // Busy follows the bytes still owed
            assert (r_busy_o == (r_rem != 0)) else fail_value("r_busy_o", r_busy_o, r_rem != 0);
            assert (w_busy_o == (w_rem != 0)) else fail_value("w_busy_o", w_busy_o, w_rem != 0);
            assert (!flush_i || (!r_valid_o && !w_valid_o))
                else fail_plain("valid raised while flush_i is high");
            // Stalled chunk keeps every field
            if (r_hold && r_valid_o) begin
                assert (r_now == r_snap) else fail_value("read fields under stall", r_now, r_snap);
            end
            if (w_hold && w_valid_o) begin
                assert (w_now == w_snap) else fail_value("write fields under stall", w_now, w_snap);
            end
            if (r_valid_o && r_ready_i) begin
                check_read();
            end
            if (w_valid_o && w_ready_i) begin
                check_write();
            end
            // Load wins over kill in the same cycle
            if (req_valid_i && req_ready_o) begin
                assert (r_rem == 0 && w_rem == 0)
                    else fail_plain("request accepted before both sides showed their last chunk");
                exp_r_addr  = src_addr_i;
                exp_w_addr  = dst_addr_i;
                r_rem       = length_i;
                w_rem       = length_i;
                exp_r_shift = src_addr_i[1:0];
                exp_w_shift = 2'(STRB_W - dst_addr_i[1:0]);
            end else if (kill_i) begin
                r_rem = 0;
                w_rem = 0;
            end
            r_hold = r_valid_o && !r_ready_i;
            w_hold = w_valid_o && !w_ready_i;
            r_snap = r_now;
            w_snap = w_now;
        end
    end

    // Offer one transfer and hold it until taken
    task automatic issue_request(input int unsigned len);
        int unsigned tries;
        tries = 0;
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        src_addr_i  <= $random(seed);
        dst_addr_i  <= $random(seed);
        length_i    <= len;
        do begin
            @(negedge clk_i);
            tries++;
            if (tries > WAIT_MAX) begin
                fail_plain("request not accepted before the timeout");
            end
        end while (!req_ready_o);
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    task automatic wait_idle();
        int unsigned tries;
        tries = 0;
        do begin
            @(negedge clk_i);
            tries++;
            if (tries > WAIT_MAX) begin
                fail_plain("transfer did not finish before the timeout");
            end
        end while (r_busy_o || w_busy_o);
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        src_addr_i  = '0;
        dst_addr_i  = '0;
        length_i    = '0;
        r_ready_i   = 1'b0;
        w_ready_i   = 1'b0;
        flush_i     = 1'b0;
        kill_i      = 1'b0;
        rand_ctrl   = 1'b0;
        r_rem       = 0;
        w_rem       = 0;
        r_hold      = 1'b0;
        w_hold      = 1'b0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        assert (!r_valid_o && !w_valid_o && !r_busy_o && !w_busy_o)
            else fail_plain("outputs not idle after reset");

        // Back-to-back transfers, lengths long enough to cross pages
        rand_ctrl = 1'b1;
        for (int i = 0; i < NUM_XFERS; i++) begin
            issue_request(1 + ({$random(seed)} % 3000));
        end
        wait_idle();

        // Kill partway through a long transfer
        issue_request(2000);
        repeat (12) @(posedge clk_i);
        kill_i <= 1'b1;
        @(posedge clk_i);
        kill_i <= 1'b0;
        @(negedge clk_i);
        assert (!r_busy_o && !w_busy_o && !r_valid_o && !w_valid_o)
            else fail_plain("a side stayed active after kill");

        // Fresh transfer after the kill
        issue_request(1 + ({$random(seed)} % 3000));
        wait_idle();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
